// File: hdl/cache_pkg.sv
// Shared widths, cache geometry and enums of the two-level memory hierarchy
package cache_pkg;

  // Host side
  localparam int ADDR_W = 6;                     // Word address
  localparam int DATA_W = 16;                    // One word per line

  // L1, two-way set associative
  localparam int L1_SETS  = 2;
  localparam int L1_WAYS  = 2;
  localparam int L1_IDX_W = $clog2(L1_SETS);     // Index is address bit 0
  localparam int L1_TAG_W = ADDR_W - L1_IDX_W;   // Tag is address bits 5 to 1

  // L2, fully associative
  localparam int L2_LINES = 8;
  localparam int L2_IDX_W = 3;                   // Also the width of a line age

  // Main memory
  localparam int MEM_WORDS  = 64;
  localparam int MEM_RD_LAT = 2;                 // Cycles from read pulse to data

  // AXI response code, only OKAY is produced
  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic
  {
    OP_READ,
    OP_WRITE
  } cache_op_t;

  // Controller states
  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,    // Dirty L2 victim goes to memory
    ST_MEM_READ,
    ST_MEM_WAIT,
    ST_FILL,         // Line written into L1 and L2
    ST_DONE
  } exec_state_t;

endpackage

// File: hdl/main_memory.sv
// Main memory, single-cycle write and fixed-latency read
`timescale 1ns/1ns

module main_memory
  import cache_pkg::*;
(
  input  logic              clock,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_wr,
  input  logic              i_rd,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_rd_valid     // One cycle, MEM_RD_LAT after i_rd
);

  logic [DATA_W-1:0]     mem [MEM_WORDS] = '{default: '0};   // Starts cleared
  logic [MEM_RD_LAT-1:0] rd_pipe = '0;
  logic [DATA_W-1:0]     data_pipe [MEM_RD_LAT];

  always_ff @(posedge clock)
  begin
    if (i_wr)
      mem[i_addr] <= i_wdata;
    // Read delay line, valid and data move together
    rd_pipe      <= {rd_pipe[MEM_RD_LAT-2:0], i_rd};
    data_pipe[0] <= mem[i_addr];
    for (int i = 1; i < MEM_RD_LAT; i++)
      data_pipe[i] <= data_pipe[i-1];
  end

  assign o_rd_valid = rd_pipe[MEM_RD_LAT-1];
  assign o_rdata    = data_pipe[MEM_RD_LAT-1];

endmodule

// File: hdl/l2_cache.sv
// Fully associative L2 with true LRU ages, dirty bits and victim selection
`timescale 1ns/1ns

module l2_cache
  import cache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic [ADDR_W-1:0] i_lookup_addr,
  input  logic              i_update,        // Write hit line, else victim
  input  logic [DATA_W-1:0] i_update_data,
  input  logic              i_update_dirty,
  output logic              o_hit,
  output logic [DATA_W-1:0] o_hit_data,
  output logic              o_victim_dirty,  // Victim needs write-back
  output logic [ADDR_W-1:0] o_victim_addr,
  output logic [DATA_W-1:0] o_victim_data
);

  logic [DATA_W-1:0]   line_data [L2_LINES];
  logic [ADDR_W-1:0]   line_addr [L2_LINES];   // Full word address as tag
  logic [L2_LINES-1:0] line_valid, line_dirty;
  logic [L2_IDX_W-1:0] line_age  [L2_LINES];   // 0 is most recent

  logic [L2_IDX_W-1:0] hit_idx, victim_idx, sel_idx, sel_age, max_age;
  logic                found_free;

  always_comb
  begin
    o_hit   = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < L2_LINES; i++)
    begin
      if (line_valid[i] && line_addr[i] == i_lookup_addr)
      begin
        o_hit   = 1'b1;
        hit_idx = L2_IDX_W'(i);
      end
    end
  end

  // Lowest invalid line, else the oldest
  always_comb
  begin
    found_free = 1'b0;
    victim_idx = '0;
    max_age    = '0;
    for (int i = 0; i < L2_LINES; i++)
    begin
      if (!line_valid[i] && !found_free)
      begin
        found_free = 1'b1;
        victim_idx = L2_IDX_W'(i);
      end
    end
    if (!found_free)
    begin
      for (int i = 0; i < L2_LINES; i++)
      begin
        if (line_age[i] > max_age)
        begin
          max_age    = line_age[i];
          victim_idx = L2_IDX_W'(i);
        end
      end
    end
  end

  assign sel_idx = o_hit ? hit_idx : victim_idx;
  // A newly filled line counts as older than every valid one
  assign sel_age = line_valid[sel_idx] ? line_age[sel_idx] : '1;

  assign o_hit_data     = line_data[hit_idx];
  assign o_victim_dirty = line_valid[victim_idx] && line_dirty[victim_idx];
  assign o_victim_addr  = line_addr[victim_idx];
  assign o_victim_data  = line_data[victim_idx];

  always_ff @(posedge clock)
  begin
    if (i_update)
    begin
      line_data[sel_idx] <= i_update_data;
      line_addr[sel_idx] <= i_lookup_addr;
    end
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      line_valid <= '0;
      line_dirty <= '0;
      for (int i = 0; i < L2_LINES; i++)
        line_age[i] <= '0;
    end
    else if (i_update)
    begin
      line_valid[sel_idx] <= 1'b1;
      line_dirty[sel_idx] <= i_update_dirty || (o_hit && line_dirty[sel_idx]);  // Dirty sticks
      for (int i = 0; i < L2_LINES; i++)
      begin
        if (L2_IDX_W'(i) == sel_idx)
          line_age[i] <= '0;                    // Most recent
        else if (line_valid[i] && line_age[i] < sel_age)
          line_age[i] <= line_age[i] + 1'b1;    // Younger lines age by one
      end
    end
  end

endmodule

// File: hdl/cache_execute.sv
// Cache controller FSM with the L1 arrays, per-set LRU and the L2 instance
`timescale 1ns/1ns

module cache_execute
  import cache_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                i_req_valid,
  input  cache_op_t           i_req_op,
  input  logic [ADDR_W-1:0]   i_req_addr,
  input  logic [L1_IDX_W-1:0] i_req_index,
  input  logic [L1_TAG_W-1:0] i_req_tag,
  input  logic [DATA_W-1:0]   i_req_wdata,
  input  logic [DATA_W-1:0]   i_mem_rdata,
  input  logic                i_mem_rd_valid,
  output logic [ADDR_W-1:0]   o_mem_addr,
  output logic [DATA_W-1:0]   o_mem_wdata,
  output logic                o_mem_wr,
  output logic                o_mem_rd,
  output logic                o_done,
  output cache_op_t           o_done_op,
  output logic [DATA_W-1:0]   o_done_data,
  output logic                o_done_hit_l1,
  output logic                o_done_hit_l2
);

  // L1 arrays, one word per line
  logic [DATA_W-1:0]   l1_data  [L1_SETS][L1_WAYS];
  logic [L1_TAG_W-1:0] l1_tag   [L1_SETS][L1_WAYS];
  logic                l1_valid [L1_SETS][L1_WAYS];
  logic                l1_lru   [L1_SETS];         // Way to replace next

  exec_state_t         state;
  cache_op_t           op_q;
  logic [ADDR_W-1:0]   addr_q;
  logic [L1_IDX_W-1:0] index_q;
  logic [L1_TAG_W-1:0] tag_q;
  logic [DATA_W-1:0]   wdata_q;
  logic [DATA_W-1:0]   fill_data;    // Line from L2 or memory
  logic [DATA_W-1:0]   done_data;
  logic                hit_l1_q, hit_l2_q;

  logic                l2_hit, l2_victim_dirty;
  logic [DATA_W-1:0]   l2_hit_data, l2_victim_data;
  logic [ADDR_W-1:0]   l2_victim_addr;

  logic                l1_hit, hit_way, repl_way, tgt_way;
  logic                lookup_commit, l1_write, l1_touch;
  logic [DATA_W-1:0]   l1_wr_data;

  // L1 tag compare in the addressed set
  always_comb
  begin
    l1_hit  = 1'b0;
    hit_way = 1'b0;
    for (int w = 0; w < L1_WAYS; w++)
    begin
      if (l1_valid[index_q][w] && l1_tag[index_q][w] == tag_q)
      begin
        l1_hit  = 1'b1;
        hit_way = 1'(w);
      end
    end
  end

  // Free way first, else the LRU way
  assign repl_way = !l1_valid[index_q][0] ? 1'b0 :
                    !l1_valid[index_q][1] ? 1'b1 : l1_lru[index_q];
  assign tgt_way  = l1_hit ? hit_way : repl_way;

  // A write commits at lookup unless it must first write back a dirty victim
  assign lookup_commit = (state == ST_LOOKUP) && (op_q == OP_WRITE) &&
                         (l2_hit || !l2_victim_dirty);
  assign l1_write   = lookup_commit || (state == ST_FILL);
  assign l1_touch   = l1_write || ((state == ST_LOOKUP) && (op_q == OP_READ) && l1_hit);
  assign l1_wr_data = (op_q == OP_WRITE) ? wdata_q : fill_data;

  always_ff @(posedge clock)
  begin
    if (l1_write)
    begin
      l1_data[index_q][tgt_way] <= l1_wr_data;
      l1_tag[index_q][tgt_way]  <= tag_q;
    end
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < L1_SETS; s++)
      begin
        l1_lru[s] <= 1'b0;
        for (int w = 0; w < L1_WAYS; w++)
        begin
          l1_valid[s][w] <= 1'b0;
        end
      end
    end
    else
    begin
      if (l1_write)
        l1_valid[index_q][tgt_way] <= 1'b1;
      if (l1_touch)
        l1_lru[index_q] <= ~tgt_way;      // Other way becomes LRU
    end
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (i_req_valid)
            state <= ST_LOOKUP;
        ST_LOOKUP:
          if (l1_touch)
            state <= ST_DONE;                              // L1 read hit or direct write
          else if (op_q == OP_READ && l2_hit)
            state <= ST_FILL;                              // Copy up from L2
          else if (l2_victim_dirty)
            state <= ST_WRITEBACK;
          else
            state <= ST_MEM_READ;
        ST_WRITEBACK:
          state <= (op_q == OP_WRITE) ? ST_FILL : ST_MEM_READ;  // Writes need no line
        ST_MEM_READ:
          state <= ST_MEM_WAIT;
        ST_MEM_WAIT:
          if (i_mem_rd_valid)
            state <= ST_FILL;
        ST_FILL:
          state <= ST_DONE;
        default:
          state <= ST_IDLE;                                // ST_DONE
      endcase
    end
  end

  // Request and result payload
  always_ff @(posedge clock)
  begin
    if (state == ST_IDLE && i_req_valid)
    begin
      op_q    <= i_req_op;
      addr_q  <= i_req_addr;
      index_q <= i_req_index;
      tag_q   <= i_req_tag;
      wdata_q <= i_req_wdata;
    end
    if (state == ST_LOOKUP)
    begin
      hit_l1_q  <= l1_hit;
      hit_l2_q  <= !l1_hit && l2_hit;   // L2 flag only when L1 missed
      fill_data <= l2_hit_data;
      done_data <= (op_q == OP_WRITE) ? wdata_q : l1_data[index_q][hit_way];
    end
    if (state == ST_MEM_WAIT && i_mem_rd_valid)
      fill_data <= i_mem_rdata;
    if (state == ST_FILL)
      done_data <= l1_wr_data;
  end

  // Memory port, victim address only during write-back
  assign o_mem_addr  = (state == ST_WRITEBACK) ? l2_victim_addr : addr_q;
  assign o_mem_wdata = l2_victim_data;
  assign o_mem_wr    = (state == ST_WRITEBACK);
  assign o_mem_rd    = (state == ST_MEM_READ);

  assign o_done        = (state == ST_DONE);
  assign o_done_op     = op_q;
  assign o_done_data   = done_data;
  assign o_done_hit_l1 = hit_l1_q;
  assign o_done_hit_l2 = hit_l2_q;

  // Every L1 write also goes to L2, dirty for host writes
  l2_cache u_l2
  (
    .clock          (clock),
    .reset          (reset),
    .i_lookup_addr  (addr_q),
    .i_update       (l1_write),
    .i_update_data  (l1_wr_data),
    .i_update_dirty (op_q == OP_WRITE),
    .o_hit          (l2_hit),
    .o_hit_data     (l2_hit_data),
    .o_victim_dirty (l2_victim_dirty),
    .o_victim_addr  (l2_victim_addr),
    .o_victim_data  (l2_victim_data)
  );

endmodule

// File: hdl/request_decode.sv
// AXI4-Lite write and read address channels, one request accepted at a time
`timescale 1ns/1ns

module request_decode
  import cache_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                i_awvalid,
  input  logic [ADDR_W-1:0]   i_awaddr,
  input  logic                i_wvalid,
  input  logic [DATA_W-1:0]   i_wdata,
  input  logic                i_arvalid,
  input  logic [ADDR_W-1:0]   i_araddr,
  input  logic                i_resp_taken,   // Response handshake done, free again
  output logic                o_awready,
  output logic                o_wready,
  output logic                o_arready,
  output logic                o_req_valid,    // One cycle per accepted request
  output cache_op_t           o_req_op,
  output logic [ADDR_W-1:0]   o_req_addr,
  output logic [L1_IDX_W-1:0] o_req_index,
  output logic [L1_TAG_W-1:0] o_req_tag,
  output logic [DATA_W-1:0]   o_req_wdata
);

  logic busy;       // A request is in flight until its response is taken
  logic write_go;   // AW and W transfer this cycle
  logic read_go;    // AR transfers this cycle

  // Write needs both address and data, and wins over a pending read
  assign write_go  = !busy && i_awvalid && i_wvalid;
  assign read_go   = !busy && i_arvalid && !(i_awvalid && i_wvalid);

  assign o_awready = write_go;
  assign o_wready  = write_go;   // AW and W accepted together
  assign o_arready = read_go;

  // The transfer itself is the request pulse, busy drops ready right after
  assign o_req_valid = write_go || read_go;
  assign o_req_op    = write_go ? OP_WRITE : OP_READ;
  assign o_req_addr  = write_go ? i_awaddr : i_araddr;
  assign o_req_wdata = i_wdata;

  // Address split for L1
  assign o_req_index = o_req_addr[L1_IDX_W-1:0];        // Set select
  assign o_req_tag   = o_req_addr[ADDR_W-1:L1_IDX_W];

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      busy <= 1'b0;
    end
    else if (o_req_valid)
    begin
      busy <= 1'b1;
    end
    else if (i_resp_taken)
    begin
      busy <= 1'b0;          // Host took the response
    end
  end

endmodule

// File: hdl/response_result.sv
// AXI4-Lite B and R channels holding the result and hit flags until accepted
`timescale 1ns/1ns

module response_result
  import cache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              i_done,
  input  cache_op_t         i_done_op,
  input  logic [DATA_W-1:0] i_done_data,
  input  logic              i_done_hit_l1,
  input  logic              i_done_hit_l2,
  input  logic              i_bready,
  input  logic              i_rready,
  output logic              o_bvalid,
  output logic [1:0]        o_bresp,
  output logic              o_rvalid,
  output logic [DATA_W-1:0] o_rdata,
  output logic [1:0]        o_rresp,
  output logic              o_hit_l1,
  output logic              o_hit_l2,
  output logic              o_resp_taken   // Handshake cycle, releases decode
);

  assign o_bresp = RESP_OKAY;
  assign o_rresp = RESP_OKAY;

  assign o_resp_taken = (o_bvalid && i_bready) || (o_rvalid && i_rready);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
      o_hit_l1 <= 1'b0;
      o_hit_l2 <= 1'b0;
    end
    else if (i_done)
    begin
      o_bvalid <= (i_done_op == OP_WRITE);   // Channel by opcode
      o_rvalid <= (i_done_op == OP_READ);
      o_hit_l1 <= i_done_hit_l1;
      o_hit_l2 <= i_done_hit_l2;
    end
    else if (o_resp_taken)
    begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
      o_hit_l1 <= 1'b0;                      // Flags only meaningful with a valid
      o_hit_l2 <= 1'b0;
    end
  end

  // Read data held stable under back-pressure
  always_ff @(posedge clock)
  begin
    if (i_done && i_done_op == OP_READ)
      o_rdata <= i_done_data;
  end

endmodule

// File: hdl/memory_hierarchy.sv
// Two-level cache hierarchy with an AXI4-Lite slave port in front of main memory
`timescale 1ns/1ns

module memory_hierarchy
  import cache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  // Write address and data
  input  logic              i_awvalid,
  output logic              o_awready,
  input  logic [ADDR_W-1:0] i_awaddr,
  input  logic              i_wvalid,
  output logic              o_wready,
  input  logic [DATA_W-1:0] i_wdata,
  // Write response
  output logic              o_bvalid,
  input  logic              i_bready,
  output logic [1:0]        o_bresp,
  // Read address
  input  logic              i_arvalid,
  output logic              o_arready,
  input  logic [ADDR_W-1:0] i_araddr,
  // Read data
  output logic              o_rvalid,
  input  logic              i_rready,
  output logic [DATA_W-1:0] o_rdata,
  output logic [1:0]        o_rresp,
  // Where the request hit, valid with BVALID or RVALID
  output logic              o_hit_l1,
  output logic              o_hit_l2
);

  // Decode to execute
  logic                req_valid;
  cache_op_t           req_op;
  logic [ADDR_W-1:0]   req_addr;
  logic [L1_IDX_W-1:0] req_index;
  logic [L1_TAG_W-1:0] req_tag;
  logic [DATA_W-1:0]   req_wdata;

  // Execute to memory
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata, mem_rdata;
  logic              mem_wr, mem_rd, mem_rd_valid;

  // Execute to result, and the release back to decode
  logic              done, done_hit_l1, done_hit_l2;
  cache_op_t         done_op;
  logic [DATA_W-1:0] done_data;
  logic              resp_taken;

  request_decode u_decode
  (
    .clock       (clock),
    .reset       (reset),
    .i_awvalid   (i_awvalid),
    .i_awaddr    (i_awaddr),
    .i_wvalid    (i_wvalid),
    .i_wdata     (i_wdata),
    .i_arvalid   (i_arvalid),
    .i_araddr    (i_araddr),
    .i_resp_taken(resp_taken),
    .o_awready   (o_awready),
    .o_wready    (o_wready),
    .o_arready   (o_arready),
    .o_req_valid (req_valid),
    .o_req_op    (req_op),
    .o_req_addr  (req_addr),
    .o_req_index (req_index),
    .o_req_tag   (req_tag),
    .o_req_wdata (req_wdata)
  );

  cache_execute u_execute
  (
    .clock          (clock),
    .reset          (reset),
    .i_req_valid    (req_valid),
    .i_req_op       (req_op),
    .i_req_addr     (req_addr),
    .i_req_index    (req_index),
    .i_req_tag      (req_tag),
    .i_req_wdata    (req_wdata),
    .i_mem_rdata    (mem_rdata),
    .i_mem_rd_valid (mem_rd_valid),
    .o_mem_addr     (mem_addr),
    .o_mem_wdata    (mem_wdata),
    .o_mem_wr       (mem_wr),
    .o_mem_rd       (mem_rd),
    .o_done         (done),
    .o_done_op      (done_op),
    .o_done_data    (done_data),
    .o_done_hit_l1  (done_hit_l1),
    .o_done_hit_l2  (done_hit_l2)
  );

  response_result u_result
  (
    .clock         (clock),
    .reset         (reset),
    .i_done        (done),
    .i_done_op     (done_op),
    .i_done_data   (done_data),
    .i_done_hit_l1 (done_hit_l1),
    .i_done_hit_l2 (done_hit_l2),
    .i_bready      (i_bready),
    .i_rready      (i_rready),
    .o_bvalid      (o_bvalid),
    .o_bresp       (o_bresp),
    .o_rvalid      (o_rvalid),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_hit_l1      (o_hit_l1),
    .o_hit_l2      (o_hit_l2),
    .o_resp_taken  (resp_taken)
  );

  main_memory u_memory
  (
    .clock      (clock),
    .i_addr     (mem_addr),
    .i_wdata    (mem_wdata),
    .i_wr       (mem_wr),
    .i_rd       (mem_rd),
    .o_rdata    (mem_rdata),
    .o_rd_valid (mem_rd_valid)
  );

endmodule

// File: tests/tb_clock.sv
// Testbench clock and reset generator, 20 ns period and reset held for 4 cycles
`timescale 1ns/1ns

module tb_clock
(
  output logic o_clock,
  output logic o_reset
);

  initial
  begin
    o_clock = 1'b0;
    forever #10 o_clock = ~o_clock;   // 20 ns period
  end

  initial
  begin
    o_reset = 1'b1;
    repeat (4) @(posedge o_clock);
    o_reset <= 1'b0;                  // Released on the fourth rising edge
  end

endmodule

// File: tests/memory_hierarchy_tb.sv
// Testbench for the cache hierarchy, directed and random traffic checked against a model
`timescale 1ns/1ns

module memory_hierarchy_tb
  import cache_pkg::*;
();

  localparam int WAIT_LIMIT = 64;   // Cycles allowed for any single handshake

  logic clock, reset;
  logic awvalid, awready, wvalid, wready, arvalid, arready;
  logic bvalid, bready, rvalid, rready, hit_l1, hit_l2;
  logic [ADDR_W-1:0] awaddr, araddr;
  logic [DATA_W-1:0] wdata, rdata;
  logic [1:0]        bresp, rresp;
  integer            seed;

  // Reference model state
  logic [DATA_W-1:0]   ref_mem    [MEM_WORDS];   // Architectural memory image
  logic                m_l1_valid [L1_SETS][L1_WAYS];
  logic [L1_TAG_W-1:0] m_l1_tag   [L1_SETS][L1_WAYS];
  int                  m_l1_lru   [L1_SETS];     // Way to replace next
  logic                m_l2_valid [L2_LINES];
  logic [ADDR_W-1:0]   m_l2_addr  [L2_LINES];
  int                  m_l2_age   [L2_LINES];    // 0 is most recent

  tb_clock u_clock
  (
    .o_clock (clock),
    .o_reset (reset)
  );

  memory_hierarchy UUT
  (
    .clock     (clock),
    .reset     (reset),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_hit_l1  (hit_l1),
    .o_hit_l2  (hit_l2)
  );

  task automatic abort_run(input string reason);
    begin
      $display("%s", reason);
      $display("Testbench failed");
      $fatal(1, "Simulation stopped on the first error");
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    begin
      if (expected !== actual)
      begin
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped on the first error");
      end
    end
  endtask

  task automatic reset_model();
    begin
      for (int a = 0; a < MEM_WORDS; a++)
        ref_mem[a] = '0;                  // Memory starts cleared
      for (int s = 0; s < L1_SETS; s++)
      begin
        m_l1_lru[s] = 0;
        for (int w = 0; w < L1_WAYS; w++)
          m_l1_valid[s][w] = 1'b0;
      end
      for (int i = 0; i < L2_LINES; i++)
      begin
        m_l2_valid[i] = 1'b0;
        m_l2_age[i]   = 0;
      end
    end
  endtask

  // L2 update: hit line, else lowest free line, else the oldest
  task automatic touch_l2(input logic [ADDR_W-1:0] addr);
    int sel;
    int oldest;
    int limit;
    begin
      sel = -1;
      for (int i = 0; i < L2_LINES; i++)
        if (m_l2_valid[i] && m_l2_addr[i] == addr)
          sel = i;
      for (int i = 0; i < L2_LINES; i++)
        if (sel < 0 && !m_l2_valid[i])
          sel = i;
      if (sel < 0)
      begin
        oldest = -1;
        for (int i = 0; i < L2_LINES; i++)
        begin
          if (m_l2_age[i] > oldest)
          begin
            oldest = m_l2_age[i];
            sel    = i;
          end
        end
      end
      limit = m_l2_valid[sel] ? m_l2_age[sel] : L2_LINES;   // New line ages all others
      for (int i = 0; i < L2_LINES; i++)
        if (i != sel && m_l2_valid[i] && m_l2_age[i] < limit)
          m_l2_age[i]++;
      m_l2_valid[sel] = 1'b1;
      m_l2_addr[sel]  = addr;
      m_l2_age[sel]   = 0;
    end
  endtask

  // Predicts data and hit flags, then moves the model to its new state
  task automatic predict_access(input logic is_write, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] exp_data,
                                output logic exp_l1, output logic exp_l2);
    int                  set_idx;
    int                  way;
    logic [L1_TAG_W-1:0] tag;
    logic                l1_hit, l2_hit;
    begin
      set_idx = int'(addr[0]);
      tag     = addr[ADDR_W-1:1];
      l1_hit  = 1'b0;
      l2_hit  = 1'b0;
      way     = 0;
      for (int w = 0; w < L1_WAYS; w++)
      begin
        if (m_l1_valid[set_idx][w] && m_l1_tag[set_idx][w] == tag)
        begin
          l1_hit = 1'b1;
          way    = w;
        end
      end
      for (int i = 0; i < L2_LINES; i++)
        if (m_l2_valid[i] && m_l2_addr[i] == addr)
          l2_hit = 1'b1;
      exp_l1 = l1_hit;
      exp_l2 = !l1_hit && l2_hit;              // L2 flag only on an L1 miss
      if (is_write)
        ref_mem[addr] = data;
      exp_data = ref_mem[addr];
      if (!l1_hit)
        way = !m_l1_valid[set_idx][0] ? 0 : (!m_l1_valid[set_idx][1] ? 1 : m_l1_lru[set_idx]);
      if (is_write || !l1_hit)
      begin
        m_l1_valid[set_idx][way] = 1'b1;
        m_l1_tag[set_idx][way]   = tag;
        touch_l2(addr);                        // A read hit in L1 leaves L2 alone
      end
      m_l1_lru[set_idx] = (way == 0) ? 1 : 0;
    end
  endtask

  // One request through the AXI port, with an optional back-pressure hold
  task automatic run_access(input logic is_write, input logic [ADDR_W-1:0] req_addr,
                            input logic [DATA_W-1:0] req_data, input string test_name,
                            input int hold_cycles, output logic [DATA_W-1:0] got_data,
                            output logic got_l1, output logic got_l2);
    logic [DATA_W-1:0] exp_data;
    logic              exp_l1, exp_l2, seen;
    int                waited;
    begin
      predict_access(is_write, req_addr, req_data, exp_data, exp_l1, exp_l2);
      @(posedge clock);
      if (is_write)
      begin
        awvalid <= 1'b1;
        awaddr  <= req_addr;
        wvalid  <= 1'b1;
        wdata   <= req_data;
      end
      else
      begin
        arvalid <= 1'b1;
        araddr  <= req_addr;
      end
      seen = 1'b0;
      for (waited = 0; waited < WAIT_LIMIT && !seen; waited++)
      begin
        @(negedge clock);
        seen = is_write ? (awready && wready) : arready;
      end
      if (!seen)
        abort_run({test_name, ": the address ready never went high"});
      @(posedge clock);                        // Transfer edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
      seen = 1'b0;
      for (waited = 0; waited < WAIT_LIMIT && !seen; waited++)
      begin
        @(negedge clock);
        seen = is_write ? bvalid : rvalid;
      end
      if (!seen)
        abort_run({test_name, ": the response valid never went high"});
      got_data = rdata;
      got_l1   = hit_l1;
      got_l2   = hit_l2;
      check_value({test_name, " other channel"}, 0, 32'(is_write ? rvalid : bvalid));
      check_value({test_name, " resp"}, 0, 32'(is_write ? bresp : rresp));
      check_value({test_name, " hit_l1"}, 32'(exp_l1), 32'(got_l1));
      check_value({test_name, " hit_l2"}, 32'(exp_l2), 32'(got_l2));
      if (!is_write)
        check_value({test_name, " rdata"}, 32'(exp_data), 32'(got_data));
      for (int c = 0; c < hold_cycles; c++)
      begin
        @(posedge clock);
        awvalid <= 1'b1;                       // Offer new requests while the response waits
        awaddr  <= req_addr;
        wvalid  <= 1'b1;
        wdata   <= req_data;
        arvalid <= 1'b1;
        araddr  <= req_addr;
        @(negedge clock);
        check_value({test_name, " held valid"}, 1, 32'(is_write ? bvalid : rvalid));
        check_value({test_name, " held hit_l1"}, 32'(got_l1), 32'(hit_l1));
        check_value({test_name, " held hit_l2"}, 32'(got_l2), 32'(hit_l2));
        check_value({test_name, " held rdata"}, 32'(got_data), 32'(rdata));
        check_value({test_name, " readies while held"}, 0, 32'({awready, wready, arready}));
      end
      @(posedge clock);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
      bready  <= is_write;
      rready  <= !is_write;
      @(posedge clock);                        // Response handshake edge
      bready  <= 1'b0;
      rready  <= 1'b0;
    end
  endtask

  initial
  begin
    logic [DATA_W-1:0] got_data;
    logic              got_l1, got_l2, is_write;
    logic [ADDR_W-1:0] addr;
    int                waited;
    seed    = 88328;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    arvalid = 1'b0;
    araddr  = '0;
    bready  = 1'b0;
    rready  = 1'b0;
    reset_model();
    waited = 0;
    @(negedge clock);
    while (reset && waited < WAIT_LIMIT)
    begin
      waited++;
      @(negedge clock);
    end
    if (reset)
      abort_run("Reset was never released");

    // Cold read, nothing cached yet
    run_access(1'b0, 6'd5, 16'h0, "cold_read", 0, got_data, got_l1, got_l2);
    check_value("cold_read value", 0, 32'(got_data));
    check_value("cold_read flags", 0, 32'({got_l1, got_l2}));

    // Write then read the same word
    run_access(1'b1, 6'd10, 16'h1234, "write_then_read", 0, got_data, got_l1, got_l2);
    run_access(1'b0, 6'd10, 16'h0, "write_then_read", 0, got_data, got_l1, got_l2);
    check_value("write_then_read value", 32'h1234, 32'(got_data));
    check_value("write_then_read hit_l1", 1, 32'(got_l1));

    // Three tags into set 0 push 20 out of L1
    run_access(1'b1, 6'd20, 16'hC014, "l1_conflict", 0, got_data, got_l1, got_l2);
    run_access(1'b1, 6'd30, 16'hC01E, "l1_conflict", 0, got_data, got_l1, got_l2);
    run_access(1'b1, 6'd40, 16'hC028, "l1_conflict", 0, got_data, got_l1, got_l2);
    run_access(1'b0, 6'd20, 16'h0, "l1_conflict", 0, got_data, got_l1, got_l2);
    check_value("l1_conflict value", 32'hC014, 32'(got_data));
    check_value("l1_conflict flags", 32'b01, 32'({got_l1, got_l2}));

    // Word 1 ends up oldest in L2 and is evicted dirty
    run_access(1'b1, 6'd1, 16'hBEEF, "write_back", 0, got_data, got_l1, got_l2);
    for (int a = 33; a < 50; a += 2)
      run_access(1'b1, ADDR_W'(a), DATA_W'(16'hA000 + a), "write_back", 0,
                 got_data, got_l1, got_l2);
    run_access(1'b0, 6'd1, 16'h0, "write_back", 0, got_data, got_l1, got_l2);
    check_value("write_back value", 32'hBEEF, 32'(got_data));
    check_value("write_back flags", 0, 32'({got_l1, got_l2}));

    // Random reads and writes
    for (int n = 0; n < 300; n++)
    begin
      is_write = 1'($random(seed));
      addr     = ADDR_W'($random(seed));
      run_access(is_write, addr, DATA_W'($random(seed)), "random_mix", 0,
                 got_data, got_l1, got_l2);
    end

    // Responses held back for a few cycles each
    for (int n = 0; n < 20; n++)
    begin
      is_write = 1'($random(seed));
      addr     = ADDR_W'($random(seed));
      run_access(is_write, addr, DATA_W'($random(seed)), "back_pressure",
                 1 + ($random(seed) & 7), got_data, got_l1, got_l2);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: compile.f
hdl/cache_pkg.sv
hdl/main_memory.sv
hdl/l2_cache.sv
hdl/cache_execute.sv
hdl/request_decode.sv
hdl/response_result.sv
hdl/memory_hierarchy.sv
tests/tb_clock.sv
tests/memory_hierarchy_tb.sv

// File: run.sh
#!/bin/sh
# Build the simulation with Verilator, run it, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --top-module memory_hierarchy_tb -f compile.f -o sim_top || exit 1
./obj_dir/sim_top > sim.log 2>&1
cat sim.log
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
grep -q "Testbench failed" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
